//--- Bender.yml
package:
  name: regfile_sub

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/regfile_pkg.sv
      - design/port_pkg.sv
      - design/req_ack_rx.sv
      - design/regfile.sv
      - design/read_rsp_tx.sv
      - design/regfile_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/regfile_checker.sv
      - testbench/tb_regfile_top.sv

//--- design/port_pkg.sv
package port_pkg;

    // write request payload
    typedef struct packed {
        regfile_pkg::reg_addr_t addr;
        regfile_pkg::reg_data_t data;
    } wr_cmd_t;

    // read request payload, address only
    typedef struct packed {
        regfile_pkg::reg_addr_t addr;
    } rd_cmd_t;

endpackage

//--- design/read_rsp_tx.sv
`timescale 1ns/1ps

module read_rsp_tx (
    input  logic                   clk,
    input  logic                   rst_n,

    // from the read path
    input  logic                   load,
    input  regfile_pkg::reg_data_t data_in,
    output logic                   ready,

    // four-phase response side
    output logic                   rsp_req,
    output regfile_pkg::reg_data_t rsp_data,
    input  logic                   rsp_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRESENT,
        ST_DROP
    } state_t;

    state_t                 state;
    regfile_pkg::reg_data_t data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state <= ST_PRESENT;
                    end
                end
                ST_PRESENT: begin
                    if (rsp_ack) begin
                        state <= ST_DROP;
                    end
                end
                // wait for the consumer to release ack
                ST_DROP: begin
                    if (!rsp_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // held stable through the whole response handshake
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && load) begin
            data_q <= data_in;
        end
    end

    assign ready    = (state == ST_IDLE);
    assign rsp_req  = (state == ST_PRESENT);
    assign rsp_data = data_q;

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

`include "regfile_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   [`REGFILE_N_WR_PORTS-1:0] wr_valid,
    input  port_pkg::wr_cmd_t      [`REGFILE_N_WR_PORTS-1:0] wr_cmd,
    output logic                   [`REGFILE_N_WR_PORTS-1:0] wr_ready,

    input  regfile_pkg::reg_addr_t [`REGFILE_N_RD_PORTS-1:0] rd_addr,
    output regfile_pkg::reg_data_t [`REGFILE_N_RD_PORTS-1:0] rd_data
);

    localparam int unsigned N_WR = `REGFILE_N_WR_PORTS;
    localparam int unsigned N_RD = `REGFILE_N_RD_PORTS;
    localparam int unsigned N_ENT = `REGFILE_N_ENTRIES;

    logic                   [N_WR-1:0]                wr_fire;
    logic                   [N_ENT-1:0][N_WR-1:0]     we_pre;
    logic                   [N_ENT-1:0]               we;
    regfile_pkg::reg_data_t [N_ENT-1:0]               din;
    regfile_pkg::reg_data_t [N_ENT-1:0]               entries;

    // a port stalls while any lower port writes the same address
    always_comb begin
        for (int i = 0; i < N_WR; i++) begin
            wr_ready[i] = 1'b1;
            for (int k = 0; k < i; k++) begin
                if (wr_valid[k] && wr_cmd[k].addr == wr_cmd[i].addr) begin
                    wr_ready[i] = 1'b0;
                end
            end
        end
    end

    assign wr_fire = wr_valid & wr_ready;

    // address decode, one enable per entry and port
    always_comb begin
        for (int j = 0; j < N_ENT; j++) begin
            for (int i = 0; i < N_WR; i++) begin
                we_pre[j][i] = wr_fire[i] &&
                               (wr_cmd[i].addr == regfile_pkg::reg_addr_t'(j));
            end
            we[j] = |we_pre[j];
        end
    end

    // at most one port hits an entry per cycle, so an OR of masked data suffices
    always_comb begin
        for (int j = 0; j < N_ENT; j++) begin
            din[j] = '0;
            for (int i = 0; i < N_WR; i++) begin
                if (we_pre[j][i]) begin
                    din[j] = din[j] | wr_cmd[i].data;
                end
            end
        end
    end

    // storage, cleared to zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entries <= '0;
        end else begin
            for (int j = 0; j < N_ENT; j++) begin
                if (we[j]) begin
                    entries[j] <= din[j];
                end
            end
        end
    end

    // read muxes see the contents before this edge's writes
    always_comb begin
        for (int r = 0; r < N_RD; r++) begin
            rd_data[r] = entries[rd_addr[r]];
        end
    end

endmodule

//--- design/regfile_pkg.sv
`include "regfile_config.svh"

package regfile_pkg;

    // width of an entry index
    localparam int unsigned ADDR_WIDTH = $clog2(`REGFILE_N_ENTRIES);

    // entry index
    typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

    // entry contents
    typedef logic [`REGFILE_ENTRY_WIDTH-1:0] reg_data_t;

endpackage

//--- design/regfile_top.sv
`timescale 1ns/1ps

`include "regfile_config.svh"

module regfile_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // write channels
    input  logic                   [`REGFILE_N_WR_PORTS-1:0] wr_req,
    input  regfile_pkg::reg_addr_t [`REGFILE_N_WR_PORTS-1:0] wr_addr,
    input  regfile_pkg::reg_data_t [`REGFILE_N_WR_PORTS-1:0] wr_data,
    output logic                   [`REGFILE_N_WR_PORTS-1:0] wr_ack,

    // read channels
    input  logic                   [`REGFILE_N_RD_PORTS-1:0] rd_req,
    input  regfile_pkg::reg_addr_t [`REGFILE_N_RD_PORTS-1:0] rd_addr,
    output logic                   [`REGFILE_N_RD_PORTS-1:0] rd_ack,

    // read responses
    output logic                   [`REGFILE_N_RD_PORTS-1:0] rsp_req,
    output regfile_pkg::reg_data_t [`REGFILE_N_RD_PORTS-1:0] rsp_data,
    input  logic                   [`REGFILE_N_RD_PORTS-1:0] rsp_ack
);

    localparam int unsigned N_WR = `REGFILE_N_WR_PORTS;
    localparam int unsigned N_RD = `REGFILE_N_RD_PORTS;

    port_pkg::wr_cmd_t      [N_WR-1:0] wr_cmd_in;
    port_pkg::wr_cmd_t      [N_WR-1:0] wr_cmd;
    logic                   [N_WR-1:0] wr_valid;
    logic                   [N_WR-1:0] wr_ready;

    port_pkg::rd_cmd_t      [N_RD-1:0] rd_cmd_in;
    port_pkg::rd_cmd_t      [N_RD-1:0] rd_cmd;
    logic                   [N_RD-1:0] rd_valid;
    logic                   [N_RD-1:0] rsp_ready;
    logic                   [N_RD-1:0] rsp_load;
    regfile_pkg::reg_addr_t [N_RD-1:0] rf_rd_addr;
    regfile_pkg::reg_data_t [N_RD-1:0] rf_rd_data;

    for (genvar i = 0; i < N_WR; i++) begin : g_wr
        assign wr_cmd_in[i].addr = wr_addr[i];
        assign wr_cmd_in[i].data = wr_data[i];

        req_ack_rx #(.payload_t(port_pkg::wr_cmd_t)) i_wr_rx (
            .clk        (clk),
            .rst_n      (rst_n),
            .req        (wr_req[i]),
            .payload_in (wr_cmd_in[i]),
            .ack        (wr_ack[i]),
            .valid      (wr_valid[i]),
            .ready      (wr_ready[i]),
            .payload    (wr_cmd[i])
        );
    end

    for (genvar r = 0; r < N_RD; r++) begin : g_rd
        assign rd_cmd_in[r].addr = rd_addr[r];
        assign rf_rd_addr[r]     = rd_cmd[r].addr;

        // a read only completes when its response holder is free
        assign rsp_load[r] = rd_valid[r] & rsp_ready[r];

        req_ack_rx #(.payload_t(port_pkg::rd_cmd_t)) i_rd_rx (
            .clk        (clk),
            .rst_n      (rst_n),
            .req        (rd_req[r]),
            .payload_in (rd_cmd_in[r]),
            .ack        (rd_ack[r]),
            .valid      (rd_valid[r]),
            .ready      (rsp_ready[r]),
            .payload    (rd_cmd[r])
        );

        read_rsp_tx i_rsp_tx (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (rsp_load[r]),
            .data_in  (rf_rd_data[r]),
            .ready    (rsp_ready[r]),
            .rsp_req  (rsp_req[r]),
            .rsp_data (rsp_data[r]),
            .rsp_ack  (rsp_ack[r])
        );
    end

    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_cmd   (wr_cmd),
        .wr_ready (wr_ready),
        .rd_addr  (rf_rd_addr),
        .rd_data  (rf_rd_data)
    );

endmodule

//--- design/req_ack_rx.sv
`timescale 1ns/1ps

module req_ack_rx #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    // four-phase side
    input  logic     req,
    input  payload_t payload_in,
    output logic     ack,

    // valid/ready side
    output logic     valid,
    input  logic     ready,
    output payload_t payload
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HOLD,
        ST_ACK
    } state_t;

    state_t   state;
    payload_t payload_q;

    // idle waits for req, hold offers the payload inward,
    // ack waits for the sender to drop req
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (ready) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // captured once per transaction
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            payload_q <= payload_in;
        end
    end

    assign valid   = (state == ST_HOLD);
    assign ack     = (state == ST_ACK);
    assign payload = payload_q;

endmodule

//--- include/regfile_config.svh
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// bits per register entry
`define REGFILE_ENTRY_WIDTH 32

// number of architectural entries
`define REGFILE_N_ENTRIES 16

// combinational read ports
`define REGFILE_N_RD_PORTS 2

// write ports, lower index commits first on a conflict
`define REGFILE_N_WR_PORTS 2

`endif

//--- regfile_sub.f
+incdir+include
design/regfile_pkg.sv
design/port_pkg.sv
design/req_ack_rx.sv
design/regfile.sv
design/read_rsp_tx.sv
design/regfile_top.sv
testbench/regfile_checker.sv
testbench/tb_regfile_top.sv

//--- testbench/regfile_checker.sv
`timescale 1ns/1ps

`include "regfile_config.svh"

module regfile_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   [`REGFILE_N_WR_PORTS-1:0] wr_req,
    input regfile_pkg::reg_addr_t [`REGFILE_N_WR_PORTS-1:0] wr_addr,
    input regfile_pkg::reg_data_t [`REGFILE_N_WR_PORTS-1:0] wr_data,
    input logic                   [`REGFILE_N_WR_PORTS-1:0] wr_ack,
    input logic                   [`REGFILE_N_RD_PORTS-1:0] rd_req,
    input regfile_pkg::reg_addr_t [`REGFILE_N_RD_PORTS-1:0] rd_addr,
    input logic                   [`REGFILE_N_RD_PORTS-1:0] rd_ack,
    input logic                   [`REGFILE_N_RD_PORTS-1:0] rsp_req,
    input regfile_pkg::reg_data_t [`REGFILE_N_RD_PORTS-1:0] rsp_data,
    input logic                   [`REGFILE_N_RD_PORTS-1:0] rsp_ack
);

    localparam int unsigned N_WR = `REGFILE_N_WR_PORTS;
    localparam int unsigned N_RD = `REGFILE_N_RD_PORTS;
    localparam int unsigned N_ENT = `REGFILE_N_ENTRIES;

    regfile_pkg::reg_data_t            shadow [N_ENT];
    regfile_pkg::reg_data_t [N_RD-1:0] exp_q;
    regfile_pkg::reg_data_t [N_RD-1:0] exp_cur;
    logic                   [N_WR-1:0] wr_ack_q;
    logic                   [N_RD-1:0] rd_ack_q;
    int unsigned                       fail_count = 0;

    // expected data is the shadow value from before the edge where rd_ack rose
    always_comb begin
        for (int r = 0; r < N_RD; r++) begin
            if (rd_ack[r] && !rd_ack_q[r]) begin
                exp_cur[r] = shadow[rd_addr[r]];
            end else begin
                exp_cur[r] = exp_q[r];
            end
        end
    end

    // shadow entries follow the wr_ack rises, lower port first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < N_ENT; j++) begin
                shadow[j] <= '0;
            end
            exp_q    <= '0;
            wr_ack_q <= '0;
            rd_ack_q <= '0;
        end else begin
            for (int i = 0; i < N_WR; i++) begin
                if (wr_ack[i] && !wr_ack_q[i]) begin
                    shadow[wr_addr[i]] <= wr_data[i];
                end
            end
            exp_q    <= exp_cur;
            wr_ack_q <= wr_ack;
            rd_ack_q <= rd_ack;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (wr_ack == '0) && (rd_ack == '0) && (rsp_req == '0))
    else begin
        fail_count++;
        $error("mismatch at %0t: ack or rsp_req high during reset", $time);
    end

    // conflicting writes never commit at the same edge
    wr_serialised: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wr_ack[0]) && $rose(wr_ack[1]) |-> wr_addr[0] != wr_addr[1])
    else begin
        fail_count++;
        $error("mismatch at %0t: both write ports committed one address", $time);
    end

    for (genvar i = 0; i < N_WR; i++) begin : g_wr
        wr_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(wr_ack[i]) |-> wr_req[i])
        else begin
            fail_count++;
            $error("mismatch at %0t: wr_ack[%0d] rose without wr_req", $time, i);
        end
    end

    for (genvar r = 0; r < N_RD; r++) begin : g_rd
        rd_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rd_ack[r]) |-> rd_req[r])
        else begin
            fail_count++;
            $error("mismatch at %0t: rd_ack[%0d] rose without rd_req", $time, r);
        end

        // a held response keeps the next read waiting
        rd_ack_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rd_ack[r]) |-> $rose(rsp_req[r]))
        else begin
            fail_count++;
            $error("mismatch at %0t: rd_ack[%0d] rose without a new response", $time, r);
        end

        rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_req[r] |-> rsp_data[r] == exp_cur[r])
        else begin
            fail_count++;
            $error("mismatch at %0t: rsp_data[%0d] is %h, expected %h",
                   $time, r, rsp_data[r], exp_cur[r]);
        end

        rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_req[r] && !rsp_ack[r] |=> rsp_req[r] && $stable(rsp_data[r]))
        else begin
            fail_count++;
            $error("mismatch at %0t: response %0d changed before rsp_ack", $time, r);
        end
    end

endmodule

//--- testbench/tb_regfile_top.sv
`timescale 1ns/1ps

`include "regfile_config.svh"

module tb_regfile_top;

    localparam int unsigned N_WR = `REGFILE_N_WR_PORTS;
    localparam int unsigned N_RD = `REGFILE_N_RD_PORTS;
    localparam int unsigned N_ENT = `REGFILE_N_ENTRIES;
    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 200;
    localparam int N_RANDOM = 300;
    localparam int SIG_WR_ACK = 0;
    localparam int SIG_RD_ACK = 1;
    localparam int SIG_RSP_REQ = 2;

    logic                              clk;
    logic                              rst_n;
    logic                   [N_WR-1:0] wr_req;
    regfile_pkg::reg_addr_t [N_WR-1:0] wr_addr;
    regfile_pkg::reg_data_t [N_WR-1:0] wr_data;
    logic                   [N_WR-1:0] wr_ack;
    logic                   [N_RD-1:0] rd_req;
    regfile_pkg::reg_addr_t [N_RD-1:0] rd_addr;
    logic                   [N_RD-1:0] rd_ack;
    logic                   [N_RD-1:0] rsp_req;
    regfile_pkg::reg_data_t [N_RD-1:0] rsp_data;
    logic                   [N_RD-1:0] rsp_ack;

    int  seed;
    int  timeouts;
    int  order_fails;
    int  fails;
    time wr_ack_time [N_WR];

    regfile_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_ack   (wr_ack),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_ack   (rd_ack),
        .rsp_req  (rsp_req),
        .rsp_data (rsp_data),
        .rsp_ack  (rsp_ack)
    );

    bind regfile_top regfile_checker i_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_ack   (wr_ack),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_ack   (rd_ack),
        .rsp_req  (rsp_req),
        .rsp_data (rsp_data),
        .rsp_ack  (rsp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic handshake_level(input int sig, input int p);
        case (sig)
            SIG_WR_ACK: handshake_level = wr_ack[p];
            SIG_RD_ACK: handshake_level = rd_ack[p];
            default:    handshake_level = rsp_req[p];
        endcase
    endfunction

    function automatic string handshake_name(input int sig);
        case (sig)
            SIG_WR_ACK: handshake_name = "wr_ack";
            SIG_RD_ACK: handshake_name = "rd_ack";
            default:    handshake_name = "rsp_req";
        endcase
    endfunction

    // polls once per rising edge until the level shows up or the limit runs out
    task automatic wait_level(input int sig, input int p, input logic level);
        int n;
        n = 0;
        while (handshake_level(sig, p) !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (handshake_level(sig, p) !== level) begin
            timeouts++;
            $display("timeout at %0t: %s[%0d] never went %s",
                     $time, handshake_name(sig), p, level ? "high" : "low");
        end
    endtask

    task automatic write_txn(input int p, input regfile_pkg::reg_addr_t a,
                             input regfile_pkg::reg_data_t d);
        @(posedge clk);
        wr_addr[p] <= a;
        wr_data[p] <= d;
        wr_req[p]  <= 1'b1;
        wait_level(SIG_WR_ACK, p, 1'b1);
        wr_ack_time[p] = $time;
        wr_req[p] <= 1'b0;
        wait_level(SIG_WR_ACK, p, 1'b0);
    endtask

    // request handshake followed by the response handshake after delay cycles
    task automatic read_txn(input int p, input regfile_pkg::reg_addr_t a, input int delay);
        @(posedge clk);
        rd_addr[p] <= a;
        rd_req[p]  <= 1'b1;
        wait_level(SIG_RD_ACK, p, 1'b1);
        rd_req[p] <= 1'b0;
        wait_level(SIG_RD_ACK, p, 1'b0);
        wait_level(SIG_RSP_REQ, p, 1'b1);
        repeat (delay) @(posedge clk);
        rsp_ack[p] <= 1'b1;
        wait_level(SIG_RSP_REQ, p, 1'b0);
        rsp_ack[p] <= 1'b0;
    endtask

    task automatic random_writes(input int p, input int count);
        regfile_pkg::reg_addr_t a;
        regfile_pkg::reg_data_t d;
        int                     gap;
        for (int k = 0; k < count; k++) begin
            a   = regfile_pkg::reg_addr_t'($random(seed));
            d   = $random(seed);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
            write_txn(p, a, d);
        end
    endtask

    task automatic random_reads(input int p, input int count);
        regfile_pkg::reg_addr_t a;
        int                     delay;
        int                     gap;
        for (int k = 0; k < count; k++) begin
            a     = regfile_pkg::reg_addr_t'($random(seed));
            delay = $unsigned($random(seed)) % 8;
            gap   = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
            read_txn(p, a, delay);
        end
    endtask

    initial begin
        seed        = 1826;
        timeouts    = 0;
        order_fails = 0;
        rst_n       = 1'b0;
        wr_req      = '0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_req      = '0;
        rd_addr     = '0;
        rsp_ack     = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // every entry starts at zero
        for (int a = 0; a < N_ENT; a += 2) begin
            fork
                read_txn(0, regfile_pkg::reg_addr_t'(a), 0);
                read_txn(1, regfile_pkg::reg_addr_t'(a + 1), 0);
            join
        end

        write_txn(0, 4'h3, 32'h1234_5678);
        read_txn(1, 4'h3, 2);

        fork
            write_txn(0, 4'h5, 32'ha5a5_0001);
            write_txn(1, 4'h9, 32'h5a5a_0002);
        join
        fork
            read_txn(0, 4'h5, 1);
            read_txn(1, 4'h9, 3);
        join

        // port 1 lands last on a shared address
        fork
            write_txn(0, 4'h7, 32'h0000_c0de);
            write_txn(1, 4'h7, 32'hc0de_0000);
        join
        assert (wr_ack_time[0] < wr_ack_time[1]) else begin
            order_fails++;
            $display("mismatch at %0t: write port 0 was not acknowledged before port 1", $time);
        end
        read_txn(0, 4'h7, 0);

        // long rsp_ack delay holds off the second read on port 0
        fork
            read_txn(0, 4'h7, 40);
            begin
                repeat (8) @(posedge clk);
                read_txn(0, 4'h5, 0);
            end
        join

        fork
            random_writes(0, N_RANDOM / 4);
            random_writes(1, N_RANDOM / 4);
            random_reads(0, N_RANDOM / 4);
            random_reads(1, N_RANDOM / 4);
        join

        repeat (5) @(posedge clk);
        fails = i_dut.i_checker.fail_count + order_fails;
        $display("timeouts: %0d, assertion failures: %0d", timeouts, fails);
        if (timeouts == 0 && fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
